/* verilog/trackerBufferPkg.sv */
`default_nettype none

package trackerBufferPkg;

	localparam int wordWidth = 12;       // Width of every stored word
	localparam int slotCount = 16;       // Event slots in the ring
	localparam int wordsPerSlot = 256;   // RAM depth of one slot
	localparam int holdLevel = 12;       // Full count that raises sendHold

	typedef logic [wordWidth-1:0] dataWord_t;
	typedef logic [$clog2(wordsPerSlot)-1:0] wordAddr_t;
	typedef logic [$clog2(slotCount)-1:0] slotIndex_t;
	typedef logic [$clog2(slotCount+1)-1:0] occupancy_t;  // 0 to 16
	typedef logic [3:0] boardAddress_t;
	typedef logic [5:0] crc_t;
	typedef logic [7:0] errInfo_t;  // {layer bits 9..5, format, chip, crc}

	localparam crc_t crcPoly = 6'h03;  // x^6+x+1

	typedef struct packed {
		logic valid;
		wordAddr_t addr;
		dataWord_t word;
	} storeWrite_t;

	typedef struct packed {
		logic valid;
		wordAddr_t count;   // Words in the finished event
		errInfo_t errInfo;
	} eventCommit_t;

	typedef struct packed {
		logic clear;       // Start of a new packet
		logic dataValid;   // Bit belongs to a chip header or cluster
		logic crcValid;    // Bit belongs to the received CRC
		logic serialBit;
	} crcStep_t;

	typedef struct packed {
		dataWord_t word;
		errInfo_t errInfo;
		logic last;
	} outWord_t;

	typedef enum logic [2:0] {idle, addr, layerHeader, chipHeader, cluster, crcField, commit}
		parserState_t;

	typedef enum logic [1:0] {waitEvent, stream, releaseSlot} readerState_t;

endpackage

`default_nettype wire

/* verilog/serialFrameParser.sv */
`timescale 1ns/1ps
`default_nettype none

module serialFrameParser
	import trackerBufferPkg::*;
(
	input wire logic Clock,
	input wire logic arstN,
	input wire logic data,                      // Serial line, idle low
	input wire boardAddress_t boardAddress,     // Expected sender address
	input wire occupancy_t slotsFull,
	input wire logic crcBad,
	output crcStep_t crcStep,
	output storeWrite_t storeWrite,
	output eventCommit_t eventCommit,
	output logic addrErrPulse,
	output logic crcErrPulse,
	output logic chipErrPulse,
	output logic dropPulse
);

	parserState_t state;
	logic [3:0] bitCnt;        // Bit position within the current field
	logic [3:0] chipsLeft;     // Chips still to come in this event
	logic [3:0] clustersLeft;  // Clusters still to come for this chip
	wordAddr_t wordAddr;       // Next word address in the slot
	dataWord_t wordShift;      // Bits received so far
	errInfo_t errBits;         // Error byte under construction
	logic dropping;            // Packet parsed but not stored

	dataWord_t assembled;
	logic startSeen;
	logic fieldEnd;
	logic dropNow;
	occupancy_t pendingFull;

	assign assembled = {wordShift[wordWidth-2:0], data};  // Word including current bit
	assign fieldEnd = (bitCnt == 4'd11);
	// A start bit may follow the last CRC bit directly
	assign startSeen = data && (state == idle || state == commit);
	// Count the commit that is going out this cycle
	assign pendingFull = slotsFull + occupancy_t'(eventCommit.valid);
	assign dropNow = (pendingFull >= occupancy_t'(slotCount));

	// CRC covers chip headers and clusters only
	always_comb begin
		crcStep.clear = startSeen;
		crcStep.dataValid = (state == chipHeader) || (state == cluster);
		crcStep.crcValid = (state == crcField);
		crcStep.serialBit = data;
	end

	// Word is written on the edge that samples its last bit
	always_comb begin
		storeWrite.valid = 1'b0;
		storeWrite.addr = wordAddr;
		storeWrite.word = assembled;
		if (!dropping && fieldEnd) begin
			case (state)
				layerHeader: begin
					storeWrite.valid = 1'b1;
					storeWrite.word = {boardAddress, assembled[7:0]};  // Layer word
				end
				chipHeader, cluster: storeWrite.valid = 1'b1;
				default: storeWrite.valid = 1'b0;
			endcase
		end
	end

	always_comb begin
		eventCommit.valid = (state == commit) && !dropping;
		eventCommit.count = wordAddr;                      // 1 + chips + clusters
		eventCommit.errInfo = {errBits[7:1], crcBad};      // CRC result ready now
	end

	always_ff @(posedge Clock) begin
		wordShift <= assembled;
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state <= idle;
			bitCnt <= '0;
			chipsLeft <= '0;
			clustersLeft <= '0;
			wordAddr <= '0;
			errBits <= '0;
			dropping <= 1'b0;
			addrErrPulse <= 1'b0;
			crcErrPulse <= 1'b0;
			chipErrPulse <= 1'b0;
			dropPulse <= 1'b0;
		end else begin
			addrErrPulse <= 1'b0;
			crcErrPulse <= 1'b0;
			chipErrPulse <= 1'b0;
			dropPulse <= 1'b0;
			bitCnt <= bitCnt + 4'd1;
			case (state)
				idle, commit: begin
					if (state == commit)
						crcErrPulse <= crcBad && !dropping;
					bitCnt <= '0;
					wordAddr <= '0;  // Layer word goes to address 0
					if (startSeen) begin
						state <= addr;
						dropping <= dropNow;  // All slots taken
						dropPulse <= dropNow;
					end else begin
						state <= idle;
					end
				end
				addr: begin
					if (bitCnt == 4'd3) begin
						bitCnt <= '0;
						if (assembled[3:0] != boardAddress) begin
							addrErrPulse <= !dropping;
							state <= idle;  // Sender pads with zeros
						end else begin
							state <= layerHeader;
						end
					end
				end
				layerHeader: begin
					if (fieldEnd) begin
						bitCnt <= '0;
						wordAddr <= wordAddr + 1'b1;
						chipsLeft <= assembled[3:0];
						errBits <= {assembled[9:5], 3'b000};  // Layer error tags
						state <= (assembled[3:0] == 4'd0) ? crcField : chipHeader;
					end
				end
				chipHeader: begin
					if (fieldEnd) begin
						bitCnt <= '0;
						wordAddr <= wordAddr + 1'b1;
						// Zero count still carries one cluster
						clustersLeft <= (assembled[9:6] == 4'd0) ? 4'd1 : assembled[9:6];
						errBits[1] <= errBits[1] | assembled[5];
						errBits[2] <= errBits[2] | assembled[10] | (assembled[9:6] == 4'd0);
						chipErrPulse <= assembled[5] && !dropping;
						state <= cluster;
					end
				end
				cluster: begin
					if (fieldEnd) begin
						bitCnt <= '0;
						wordAddr <= wordAddr + 1'b1;
						clustersLeft <= clustersLeft - 4'd1;
						if (clustersLeft == 4'd1) begin  // End of this chip
							chipsLeft <= chipsLeft - 4'd1;
							state <= (chipsLeft == 4'd1) ? crcField : chipHeader;
						end
					end
				end
				crcField: begin
					if (bitCnt == 4'd5)
						state <= commit;
				end
				default: state <= idle;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/crcCheck.sv */
`timescale 1ns/1ps
`default_nettype none

module crcCheck
	import trackerBufferPkg::*;
(
	input wire logic Clock,
	input wire logic arstN,
	input wire crcStep_t crcStep,
	output logic crcBad        // Latched mismatch for the current packet
);

	crc_t crcReg;
	logic feedback;

	// Also the mismatch of a received CRC bit against the expected MSB
	assign feedback = crcReg[5] ^ crcStep.serialBit;

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			crcReg <= '0;
			crcBad <= 1'b0;
		end else if (crcStep.clear) begin
			crcReg <= '0;    // New packet
			crcBad <= 1'b0;
		end else if (crcStep.dataValid) begin
			// Galois step
			crcReg <= {crcReg[4:0], 1'b0} ^ (feedback ? crcPoly : crc_t'(0));
		end else if (crcStep.crcValid) begin
			crcBad <= crcBad | feedback;
			crcReg <= {crcReg[4:0], 1'b0};  // Expose next expected bit
		end
	end

endmodule

`default_nettype wire

/* verilog/eventStore.sv */
`timescale 1ns/1ps
`default_nettype none

module eventStore
	import trackerBufferPkg::*;
(
	input wire logic Clock,
	input wire logic arstN,
	input wire storeWrite_t storeWrite,
	input wire eventCommit_t eventCommit,
	input wire wordAddr_t readAddr,
	input wire logic readRelease,      // Slot at readPtr is done
	output dataWord_t readWord,        // One cycle after readAddr
	output wordAddr_t readCount,
	output errInfo_t readErr,
	output logic eventAvailable,
	output occupancy_t slotsFull,
	output logic sendHold
);

	dataWord_t ram [slotCount][wordsPerSlot];
	wordAddr_t wordCount [slotCount];  // Words per stored event
	errInfo_t errArray [slotCount];    // Error byte per stored event
	slotIndex_t writePtr;              // Slot being filled
	slotIndex_t readPtr;               // Oldest full slot

	always_ff @(posedge Clock) begin
		if (storeWrite.valid)
			ram[writePtr][storeWrite.addr] <= storeWrite.word;
		readWord <= ram[readPtr][readAddr];  // Registered read
	end

	always_ff @(posedge Clock) begin
		if (eventCommit.valid) begin
			wordCount[writePtr] <= eventCommit.count;
			errArray[writePtr] <= eventCommit.errInfo;
		end
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			writePtr <= '0;
			readPtr <= '0;
			slotsFull <= '0;
		end else begin
			if (eventCommit.valid)
				writePtr <= writePtr + 1'b1;  // Wraps around the ring
			if (readRelease)
				readPtr <= readPtr + 1'b1;
			case ({eventCommit.valid, readRelease})
				2'b10: slotsFull <= slotsFull + 1'b1;
				2'b01: slotsFull <= slotsFull - 1'b1;
				default: slotsFull <= slotsFull;  // None or both
			endcase
		end
	end

	assign readCount = wordCount[readPtr];
	assign readErr = errArray[readPtr];
	assign eventAvailable = (slotsFull != '0);
	assign sendHold = (slotsFull >= occupancy_t'(holdLevel));  // Ask upstream to pause

endmodule

`default_nettype wire

/* verilog/eventReader.sv */
`timescale 1ns/1ps
`default_nettype none

module eventReader
	import trackerBufferPkg::*;
(
	input wire logic Clock,
	input wire logic arstN,
	input wire logic eventAvailable,
	input wire dataWord_t readWord,
	input wire wordAddr_t readCount,
	input wire errInfo_t readErr,
	output wordAddr_t readAddr,
	output logic readRelease,
	output outWord_t eventOut,
	output logic outValid,
	input wire logic outReady
);

	readerState_t state;
	wordAddr_t fetchAddr;  // Address of the word now on readWord
	logic fetchValid;      // readWord holds an unsent word
	logic advance;
	logic consume;
	logic lastWord;

	assign advance = !outValid || outReady;  // Output register free at this edge
	assign consume = fetchValid && advance;
	assign lastWord = (fetchAddr == readCount - 1'b1);
	// Re-read the same word while it waits
	assign readAddr = consume ? fetchAddr + 1'b1 : fetchAddr;

	always_ff @(posedge Clock) begin
		if (consume)
			eventOut <= '{word: readWord, errInfo: readErr, last: lastWord};
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state <= waitEvent;
			fetchAddr <= '0;
			fetchValid <= 1'b0;
			outValid <= 1'b0;
			readRelease <= 1'b0;
		end else begin
			readRelease <= 1'b0;
			fetchAddr <= readAddr;
			if (advance)
				outValid <= fetchValid;
			case (state)
				waitEvent: begin
					// Count still includes a slot being released
					if (eventAvailable && !readRelease) begin
						fetchValid <= 1'b1;  // Word 0 arrives next cycle
						state <= stream;
					end
				end
				stream: begin
					if (consume && lastWord) begin
						fetchValid <= 1'b0;
						state <= releaseSlot;
					end
				end
				releaseSlot: begin
					if (outReady) begin  // Last word taken
						readRelease <= 1'b1;
						fetchAddr <= '0;
						state <= waitEvent;
					end
				end
				default: state <= waitEvent;
			endcase
		end
	end

endmodule

`default_nettype wire

/* verilog/trackerEventBuffer.sv */
`timescale 1ns/1ps
`default_nettype none

module trackerEventBuffer
	import trackerBufferPkg::*;
(
	input wire logic Clock,
	input wire logic arstN,
	input wire logic data,                    // Serial stream from the front-end board
	input wire boardAddress_t boardAddress,
	output outWord_t eventOut,
	output logic outValid,
	input wire logic outReady,
	output occupancy_t slotsFull,
	output logic sendHold,
	output logic addrErrPulse,
	output logic crcErrPulse,
	output logic chipErrPulse,
	output logic dropPulse
);

	crcStep_t crcStep;
	logic crcBad;
	storeWrite_t storeWrite;
	eventCommit_t eventCommit;
	wordAddr_t readAddr;
	logic readRelease;
	dataWord_t readWord;
	wordAddr_t readCount;
	errInfo_t readErr;
	logic eventAvailable;

	serialFrameParser frameParser (
		.Clock(Clock),
		.arstN(arstN),
		.data(data),
		.boardAddress(boardAddress),
		.slotsFull(slotsFull),
		.crcBad(crcBad),
		.crcStep(crcStep),
		.storeWrite(storeWrite),
		.eventCommit(eventCommit),
		.addrErrPulse(addrErrPulse),
		.crcErrPulse(crcErrPulse),
		.chipErrPulse(chipErrPulse),
		.dropPulse(dropPulse)
	);

	crcCheck crcChecker (
		.Clock(Clock),
		.arstN(arstN),
		.crcStep(crcStep),
		.crcBad(crcBad)
	);

	eventStore store (
		.Clock(Clock),
		.arstN(arstN),
		.storeWrite(storeWrite),
		.eventCommit(eventCommit),
		.readAddr(readAddr),
		.readRelease(readRelease),
		.readWord(readWord),
		.readCount(readCount),
		.readErr(readErr),
		.eventAvailable(eventAvailable),
		.slotsFull(slotsFull),
		.sendHold(sendHold)
	);

	eventReader reader (
		.Clock(Clock),
		.arstN(arstN),
		.eventAvailable(eventAvailable),
		.readWord(readWord),
		.readCount(readCount),
		.readErr(readErr),
		.readAddr(readAddr),
		.readRelease(readRelease),
		.eventOut(eventOut),
		.outValid(outValid),
		.outReady(outReady)
	);

endmodule

`default_nettype wire

/* testbench/clockGen.sv */
`timescale 1ns/1ps
`default_nettype none

module clockGen (
	output logic Clock,
	output logic arstN
);

	localparam int halfPeriod = 20;   // 40 ns clock
	localparam int resetCycles = 8;

	initial begin
		Clock = 1'b0;
		forever #(halfPeriod) Clock = ~Clock;
	end

	initial begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge Clock);
		#1 arstN = 1'b1;  // Release just after an edge
	end

endmodule

`default_nettype wire

/* testbench/trackerEventBufferTb.sv */
`timescale 1ns/1ps
`default_nettype none

module trackerEventBufferTb
	import trackerBufferPkg::*;
();

	localparam boardAddress_t ourBoard = 4'h9;
	localparam int fullSlots = 16;     // Ring size
	localparam int holdAt = 12;        // Full count that raises sendHold
	localparam int randPackets = 60;
	localparam int fullPackets = 20;   // Four more than the ring holds
	localparam int maxPacketBits = 1 + 4 + 12 + 4 * 4 * 12 + 6;  // 4 chips of 3 clusters
	localparam int maxGap = 8;
	localparam int cycleLimit = (randPackets + fullPackets) * (maxPacketBits + maxGap) * 2 + 4000;

	typedef enum {readyRandom, readyLow} readyMode_t;

	logic Clock, arstN, data, outReady, outValid, sendHold;
	logic addrErrPulse, crcErrPulse, chipErrPulse, dropPulse;
	boardAddress_t boardAddress;
	outWord_t eventOut;
	occupancy_t slotsFull;

	logic [31:0] lfsr = 32'h4769_c3e3;
	readyMode_t readyMode;
	string testName;
	logic pktBits[$];         // Serial bits of the packet being sent
	dataWord_t pktWords[$];   // Words the model expects in the slot
	errInfo_t pktErr;
	crc_t pktCrc;
	int pktChipErrs;
	outWord_t expQ[$];        // Expected output stream
	outWord_t expWord;
	int wordErrors = 0, statusErrors = 0, cycleCount = 0;
	int addrErrExp = 0, crcErrExp = 0, chipErrExp = 0, dropExp = 0;
	int addrErrSeen = 0, crcErrSeen = 0, chipErrSeen = 0, dropSeen = 0;

	clockGen clocks (.Clock(Clock), .arstN(arstN));

	trackerEventBuffer uut (
		.Clock(Clock), .arstN(arstN), .data(data), .boardAddress(boardAddress),
		.eventOut(eventOut), .outValid(outValid), .outReady(outReady),
		.slotsFull(slotsFull), .sendHold(sendHold), .addrErrPulse(addrErrPulse),
		.crcErrPulse(crcErrPulse), .chipErrPulse(chipErrPulse), .dropPulse(dropPulse)
	);

	// Galois LFSR stepped once per bit drawn
	function automatic logic nextBit();
		logic outBit;
		outBit = lfsr[0];
		lfsr = lfsr >> 1;
		if (outBit)
			lfsr = lfsr ^ 32'hD000_0001;
		return outBit;
	endfunction

	function automatic logic [31:0] randBits(input int count);
		logic [31:0] value;
		value = '0;
		repeat (count) value = {value[30:0], nextBit()};
		return value;
	endfunction

	// Append a field MSB first and feed it to the x^6+x+1 CRC if asked
	task automatic pushField(input logic [11:0] value, input int width, input logic toCrc);
		int i;
		logic fb;
		for (i = width - 1; i >= 0; i--) begin
			pktBits.push_back(value[i]);
			fb = pktCrc[5] ^ value[i];
			if (toCrc)
				pktCrc = {pktCrc[4:0], 1'b0} ^ (fb ? 6'h03 : 6'h00);
		end
	endtask

	task automatic buildPacket(input logic badAddr, input logic badCrc);
		logic [3:0] addrBits;
		logic [11:0] layer;
		logic [11:0] chipHdr;
		int chips, clusters, c, k;
		pktBits.delete();
		pktWords.delete();
		pktCrc = '0;
		pktChipErrs = 0;
		addrBits = badAddr ? 4'(randBits(4)) : ourBoard;
		if (badAddr && addrBits == ourBoard)
			addrBits = addrBits ^ 4'h1;
		pushField(12'h001, 1, 1'b0);  // Start bit
		pushField(12'(addrBits), 4, 1'b0);
		if (badAddr) begin
			pushField(12'h000, 12, 1'b0);  // Zero padding after a refused address
			return;
		end
		chips = int'(randBits(3) % 5);
		layer = 12'(randBits(12));
		layer[3:0] = 4'(chips);
		pushField(layer, 12, 1'b0);
		pktWords.push_back({ourBoard, layer[7:0]});  // Layer word
		pktErr = {layer[9:5], 3'b000};
		for (c = 0; c < chips; c++) begin
			chipHdr = 12'(randBits(12));
			chipHdr[9:6] = 4'(randBits(2));     // Cluster count 0 to 3
			chipHdr[10] = (randBits(3) == 0);   // Occasional bad format bit
			clusters = (chipHdr[9:6] == 4'd0) ? 1 : int'(chipHdr[9:6]);
			pktErr[1] = pktErr[1] | chipHdr[5];
			pktErr[2] = pktErr[2] | chipHdr[10] | (chipHdr[9:6] == 4'd0);
			if (chipHdr[5])
				pktChipErrs++;
			pushField(chipHdr, 12, 1'b1);
			pktWords.push_back(chipHdr);
			for (k = 0; k < clusters; k++) begin
				pktWords.push_back(12'(randBits(12)));
				pushField(pktWords[pktWords.size() - 1], 12, 1'b1);
			end
		end
		if (badCrc) begin
			pktCrc = pktCrc ^ (6'd1 << (randBits(3) % 6));  // Flip one CRC bit
			pktErr[0] = 1'b1;
		end
		pushField(12'(pktCrc), 6, 1'b0);
	endtask

	task automatic queueEvent();
		int i;
		for (i = 0; i < pktWords.size(); i++)
			expQ.push_back('{word: pktWords[i], errInfo: pktErr,
				last: (i == pktWords.size() - 1)});
	endtask

	// One clock of stimulus driven 1 ns after the edge
	task automatic stepCycle(input logic serialBit);
		data = serialBit;
		if (readyMode == readyLow)
			outReady = 1'b0;
		else
			outReady = nextBit();
		@(posedge Clock);
		#1;
	endtask

	task automatic sendPacket(input int gap);
		int i;
		for (i = 0; i < pktBits.size(); i++)
			stepCycle(pktBits[i]);
		repeat (gap) stepCycle(1'b0);
	endtask

	task automatic drain();
		while (expQ.size() != 0 || slotsFull != '0 || outValid)
			stepCycle(1'b0);
	endtask

	task automatic checkCount(input string what, input int expected, input int actual);
		if (expected != actual) begin
			statusErrors++;
			$display("[FAIL] %s: %s expected %0d actual %0d", testName, what, expected, actual);
		end
	endtask

	task automatic checkPulses();
		checkCount("addrErrPulse count", addrErrExp, addrErrSeen);
		checkCount("crcErrPulse count", crcErrExp, crcErrSeen);
		checkCount("chipErrPulse count", chipErrExp, chipErrSeen);
		checkCount("dropPulse count", dropExp, dropSeen);
	endtask

	// Outputs are stable mid-cycle and transfer at the next rising edge
	always @(negedge Clock) begin
		if (arstN) begin
			if (outValid && outReady) begin
				if (expQ.size() == 0) begin
					wordErrors++;
					$display("%s: output word %h arrived with no event pending", testName,
						eventOut.word);
				end else begin
					expWord = expQ.pop_front();
					if (eventOut !== expWord) begin
						wordErrors++;
						// Word, error byte and last flag
						$display("[FAIL] %s: expected %h/%h/%b actual %h/%h/%b",
							testName, expWord.word, expWord.errInfo, expWord.last,
							eventOut.word, eventOut.errInfo, eventOut.last);
					end
				end
			end
			if (addrErrPulse) addrErrSeen++;
			if (crcErrPulse) crcErrSeen++;
			if (chipErrPulse) chipErrSeen++;
			if (dropPulse) dropSeen++;
		end
	end

	always @(posedge Clock) begin
		cycleCount++;
		if (cycleCount > cycleLimit) begin
			$display("Timeout: run still busy after %0d cycles", cycleLimit);
			$display("TEST FAILED");
			$finish;
		end
	end

	initial begin
		int p, expFull;
		logic badAddr, badCrc;
		data = 1'b0;
		outReady = 1'b0;
		boardAddress = ourBoard;
		readyMode = readyRandom;
		testName = "reset";
		@(posedge arstN);
		@(posedge Clock);
		#1;
		if (outValid !== 1'b0 || slotsFull !== '0 || sendHold !== 1'b0) begin
			statusErrors++;
			$display("[FAIL] %s: outValid/slotsFull/sendHold expected 0/0/0 actual %b/%0d/%b",
				testName, outValid, slotsFull, sendHold);
		end

		// Mixed traffic under random back-pressure
		testName = "randomTraffic";
		for (p = 0; p < randPackets; p++) begin
			badAddr = (randBits(3) == 0);
			badCrc = (randBits(3) == 0);
			buildPacket(badAddr, badCrc);
			if (badAddr) begin
				addrErrExp++;
			end else begin
				queueEvent();
				chipErrExp += pktChipErrs;
				if (badCrc)
					crcErrExp++;
			end
			sendPacket(int'(randBits(3)));  // Gap 0 gives back-to-back packets
		end
		drain();
		checkPulses();

		// Reader stalled until the ring overflows
		testName = "fullBuffer";
		readyMode = readyLow;
		for (p = 0; p < fullPackets; p++) begin
			buildPacket(1'b0, 1'b0);
			if (p < fullSlots) begin
				queueEvent();
				chipErrExp += pktChipErrs;
			end else begin
				dropExp++;
			end
			sendPacket(2);
			expFull = (p < fullSlots) ? p + 1 : fullSlots;
			if (slotsFull !== occupancy_t'(expFull)) begin
				statusErrors++;
				$display("[FAIL] %s: slotsFull expected %0d actual %0d", testName,
					expFull, slotsFull);
			end
			if (sendHold !== (expFull >= holdAt)) begin
				statusErrors++;
				$display("[FAIL] %s: sendHold expected %b actual %b", testName,
					(expFull >= holdAt), sendHold);
			end
		end
		readyMode = readyRandom;
		drain();
		checkPulses();

		$display("Errors: %0d output word, %0d status", wordErrors, statusErrors);
		if (wordErrors + statusErrors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

/* trackerEventBuffer.f */
verilog/trackerBufferPkg.sv
verilog/serialFrameParser.sv
verilog/crcCheck.sv
verilog/eventStore.sv
verilog/eventReader.sv
verilog/trackerEventBuffer.sv
testbench/clockGen.sv
testbench/trackerEventBufferTb.sv

/* Makefile */
SOURCES := $(shell cat trackerEventBuffer.f)

.PHONY: run clean

run: obj_dir/VtrackerEventBufferTb
	./obj_dir/VtrackerEventBufferTb > sim.log 2>&1; cat sim.log
	grep -q "TEST OK" sim.log

obj_dir/VtrackerEventBufferTb: trackerEventBuffer.f $(SOURCES)
	verilator --binary -Wno-fatal --top-module trackerEventBufferTb -f trackerEventBuffer.f

clean:
	rm -rf obj_dir sim.log
